// File: Bender.yml
package:
  name: exception_unit

sources:
  - hdl/exception_pkg.sv
  - hdl/exception_intf.sv
  - hdl/exception.sv
  - hdl/cp0_regs.sv
  - hdl/pc_select.sv
  - hdl/hazard.sv
  - hdl/exception_top.sv
  - target: simulation
    files:
      - dv/exception_tb.sv

// File: dv/exception_tb.sv
`timescale 1ns/1ns

module exception_tb
    import exception_pkg::*;
();
    localparam int NUM_CYCLES   = 3000;
    localparam int RESET_CYCLES = 10;
    localparam int CLK_PERIOD   = 10;
    localparam int MARGIN_NS    = 500;

    logic            clk = 1'b0;
    logic            reset;
    exception_info_t exc_info;
    word_t           pcplus8;
    logic            in_delay_slot;
    word_t           badvaddr;
    logic            eret;
    logic            branch_taken;
    word_t           branch_target;
    logic            stall;
    logic            cp0_we;
    cp0_addr_t       cp0_addr;
    word_t           cp0_wdata;
    word_t           pc;
    word_t           cp0_rdata;
    logic            flush;
    logic            exception_valid;
    exc_code_t       exc_code;

    // reference state mirroring fetch pc, cp0 and the held redirect
    word_t      m_pc;
    logic       m_bev;
    logic [7:0] m_im;
    logic       m_erl;
    logic       m_exl;
    logic       m_ie;
    logic       m_bd;
    exc_code_t  m_code;
    word_t      m_epc;
    word_t      m_badvaddr;
    logic       m_hold;
    word_t      m_redirect;

    integer seed;

    exception_top i_dut (
        .clk             (clk),
        .reset           (reset),
        .exc_info        (exc_info),
        .pcplus8         (pcplus8),
        .in_delay_slot   (in_delay_slot),
        .badvaddr        (badvaddr),
        .eret            (eret),
        .branch_taken    (branch_taken),
        .branch_target   (branch_target),
        .stall           (stall),
        .cp0_we          (cp0_we),
        .cp0_addr        (cp0_addr),
        .cp0_wdata       (cp0_wdata),
        .pc              (pc),
        .cp0_rdata       (cp0_rdata),
        .flush           (flush),
        .exception_valid (exception_valid),
        .exc_code        (exc_code)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // fetch error first and store error last
    function automatic exc_code_t expected_code(exception_info_t f);
        exc_code_t c;
        c = '0;
        if (f.instr) begin
            c = CODE_ADEL;
        end else if (f.ri) begin
            c = CODE_RI;
        end else if (f.of) begin
            c = CODE_OV;
        end else if (f.sys) begin
            c = CODE_SYS;
        end else if (f.bp) begin
            c = CODE_BP;
        end else if (f.load) begin
            c = CODE_ADEL;
        end else if (f.save) begin
            c = CODE_ADES;
        end
        return c;
    endfunction

    // mfc0 view of the reference registers
    function automatic word_t model_read(cp0_addr_t addr);
        word_t w;
        w = '0;
        case (addr)
            CP0_STATUS: begin
                w[STATUS_BEV_BIT]     = m_bev;
                w[STATUS_IM_LSB +: 8] = m_im;
                w[STATUS_ERL_BIT]     = m_erl;
                w[STATUS_EXL_BIT]     = m_exl;
                w[STATUS_IE_BIT]      = m_ie;
            end
            CP0_CAUSE: begin
                w[CAUSE_BD_BIT]        = m_bd;
                w[CAUSE_EXC_LSB +: 5]  = m_code;
            end
            CP0_EPC:      w = m_epc;
            CP0_BADVADDR: w = m_badvaddr;
            default:      w = '0;
        endcase
        return w;
    endfunction

    task automatic compare_field(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t ns: %s is %h, model expects %h", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic reset_model();
        m_pc       = RESET_PC;
        m_bev      = 1'b1;
        m_im       = '0;
        m_erl      = 1'b1;
        m_exl      = 1'b0;
        m_ie       = 1'b0;
        m_bd       = 1'b0;
        m_code     = '0;
        m_epc      = '0;
        m_badvaddr = '0;
        m_hold     = 1'b0;
        m_redirect = '0;
    endtask

    // combinational outputs and state sampled mid cycle
    task automatic check_outputs();
        logic exc_v;
        exc_v = (exc_info != '0);
        compare_field("exception_valid", exception_valid, exc_v);
        compare_field("exc_code", exc_code, expected_code(exc_info));
        compare_field("flush", flush, exc_v || eret);
        compare_field("pc", pc, m_pc);
        compare_field("cp0_rdata", cp0_rdata, model_read(cp0_addr));
    endtask

    // state after the coming edge from the inputs now applied
    task automatic advance_model();
        logic      exc_v;
        logic      eret_v;
        logic      redirect_now;
        logic      addr_err;
        exc_code_t code;
        exc_v        = (exc_info != '0);
        eret_v       = eret && !exc_v;
        redirect_now = exc_v || eret_v;
        code         = expected_code(exc_info);
        // address error flag taken only when no earlier cause wins
        addr_err     = exc_info.instr
                       || (!exc_info.ri && !exc_info.of && !exc_info.sys && !exc_info.bp
                           && (exc_info.load || exc_info.save));
        // fetch side uses epc before any cp0 update
        if (!stall) begin
            if (m_hold) begin
                m_pc = m_redirect;
            end else if (exc_v) begin
                m_pc = EXC_ENTRY;
            end else if (eret_v) begin
                m_pc = m_epc;
            end else if (branch_taken) begin
                m_pc = branch_target;
            end else begin
                m_pc = m_pc + 32'd4;
            end
            m_hold = 1'b0;
        end else if (redirect_now) begin
            m_hold     = 1'b1;
            m_redirect = exc_v ? EXC_ENTRY : m_epc;
        end
        // cp0 priority is exception then eret then mtc0
        if (exc_v) begin
            m_code = code;
            if (!m_exl) begin
                m_epc = in_delay_slot ? pcplus8 - 32'd12 : pcplus8 - 32'd8;
                m_bd  = in_delay_slot;
            end
            m_exl = 1'b1;
            if (addr_err) begin
                m_badvaddr = badvaddr;
            end
        end else if (eret_v) begin
            m_exl = 1'b0;
        end else if (cp0_we) begin
            if (cp0_addr == CP0_STATUS) begin
                m_bev = cp0_wdata[STATUS_BEV_BIT];
                m_im  = cp0_wdata[STATUS_IM_LSB +: 8];
                m_erl = cp0_wdata[STATUS_ERL_BIT];
                m_exl = cp0_wdata[STATUS_EXL_BIT];
                m_ie  = cp0_wdata[STATUS_IE_BIT];
            end else if (cp0_addr == CP0_EPC) begin
                m_epc = cp0_wdata;
            end else if (cp0_addr == CP0_BADVADDR) begin
                m_badvaddr = cp0_wdata;
            end
        end
    endtask

    // new inputs right after the edge
    task automatic drive_random();
        int          pick;
        logic [6:0]  flags;
        cp0_addr_t   addr;
        pick  = {$random(seed)} % 16;
        flags = '0;
        if (pick == 0) begin
            flags = 7'b1 << ({$random(seed)} % 7);
        end else if (pick == 1) begin
            // several flags so priority decides
            flags = $random(seed);
            flags = flags | (7'b1 << ({$random(seed)} % 7));
        end
        case ({$random(seed)} % 5)
            0:       addr = CP0_STATUS;
            1:       addr = CP0_CAUSE;
            2:       addr = CP0_EPC;
            3:       addr = CP0_BADVADDR;
            default: addr = $random(seed);
        endcase
        exc_info      <= flags;
        pcplus8       <= $random(seed) & 32'hFFFF_FFFC;
        in_delay_slot <= $random(seed);
        badvaddr      <= $random(seed);
        eret          <= ({$random(seed)} % 16) == 0;
        stall         <= ({$random(seed)} % 4) == 0;
        branch_taken  <= ({$random(seed)} % 4) == 0;
        branch_target <= $random(seed) & 32'hFFFF_FFFC;
        cp0_we        <= ({$random(seed)} % 8) == 0;
        cp0_addr      <= addr;
        // epc feeds fetch and must stay aligned
        if (addr == CP0_EPC) begin
            cp0_wdata <= $random(seed) & 32'hFFFF_FFFC;
        end else begin
            cp0_wdata <= $random(seed);
        end
    endtask

    initial begin
        seed          = 37;
        reset         = 1'b1;
        exc_info      = '0;
        pcplus8       = '0;
        in_delay_slot = 1'b0;
        badvaddr      = '0;
        eret          = 1'b0;
        branch_taken  = 1'b0;
        branch_target = '0;
        stall         = 1'b0;
        cp0_we        = 1'b0;
        cp0_addr      = CP0_STATUS;
        cp0_wdata     = '0;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        drive_random();
        repeat (NUM_CYCLES) begin
            @(negedge clk);
            check_outputs();
            advance_model();
            @(posedge clk);
            drive_random();
        end
        $display("Regression passed");
        $finish;
    end

    // upper bound on run length
    initial begin
        #((RESET_CYCLES + NUM_CYCLES) * CLK_PERIOD + MARGIN_NS);
        $display("test timed out before all cycles were checked");
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: exception_unit.f
hdl/exception_pkg.sv
hdl/exception_intf.sv
hdl/exception.sv
hdl/cp0_regs.sv
hdl/pc_select.sv
hdl/hazard.sv
hdl/exception_top.sv
dv/exception_tb.sv

// File: hdl/cp0_regs.sv
`timescale 1ns/1ns

module cp0_regs
    import exception_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      eret,
    input  logic      cp0_we,
    input  cp0_addr_t cp0_addr,
    input  word_t     cp0_wdata,
    output word_t     cp0_rdata,
    exception_intf.cp0 excep,
    pcselect_intf.cp0 pcselect,
    hazard_intf.cp0 hazard
);
    cp0_status_t status;
    logic        cause_bd;
    exc_code_t   cause_exccode;
    word_t       epc;
    word_t       badvaddr;

    exception_t  exc;
    logic        eret_valid;
    logic        addr_error;
    word_t       epc_next;
    word_t       status_word;
    word_t       cause_word;

    assign exc = excep.exception;

    // eret only counts when no exception shares the cycle
    assign eret_valid = eret & ~exc.valid;

    // address errors also capture the faulting address
    assign addr_error = (exc.code == CODE_ADEL) || (exc.code == CODE_ADES);

    // victim pc or the branch pc in a delay slot
    assign epc_next = exc.in_delay_slot ? exc.pcplus8 - 32'd12
                                        : exc.pcplus8 - 32'd8;

    always_ff @(posedge clk) begin
        if (reset) begin
            status        <= '0;
            status.ERL    <= 1'b1;
            status.BEV    <= 1'b1;
            cause_bd      <= 1'b0;
            cause_exccode <= '0;
            epc           <= '0;
            badvaddr      <= '0;
        end else if (exc.valid) begin
            // stall does not hold back the cp0 update
            cause_exccode <= exc.code;
            // nested exception keeps the first epc
            if (!status.EXL) begin
                epc      <= epc_next;
                cause_bd <= exc.in_delay_slot;
            end
            status.EXL <= 1'b1;
            if (addr_error) begin
                badvaddr <= exc.badvaddr;
            end
        end else if (eret_valid) begin
            status.EXL <= 1'b0;
        end else if (cp0_we) begin
            // mtc0 leaves cause untouched
            case (cp0_addr)
                CP0_STATUS: begin
                    status.BEV <= cp0_wdata[STATUS_BEV_BIT];
                    status.IM  <= cp0_wdata[STATUS_IM_LSB +: 8];
                    status.ERL <= cp0_wdata[STATUS_ERL_BIT];
                    status.EXL <= cp0_wdata[STATUS_EXL_BIT];
                    status.IE  <= cp0_wdata[STATUS_IE_BIT];
                end
                CP0_EPC:      epc      <= cp0_wdata;
                CP0_BADVADDR: badvaddr <= cp0_wdata;
                default: ;
            endcase
        end
    end

    // pack kept fields back into architectural layout
    always_comb begin
        status_word                           = '0;
        status_word[STATUS_BEV_BIT]           = status.BEV;
        status_word[STATUS_IM_LSB +: 8]       = status.IM;
        status_word[STATUS_ERL_BIT]           = status.ERL;
        status_word[STATUS_EXL_BIT]           = status.EXL;
        status_word[STATUS_IE_BIT]            = status.IE;
    end

    always_comb begin
        cause_word                      = '0;
        cause_word[CAUSE_BD_BIT]        = cause_bd;
        cause_word[CAUSE_EXC_LSB +: 5]  = cause_exccode;
    end

    // mfc0 read port
    always_comb begin
        case (cp0_addr)
            CP0_BADVADDR: cp0_rdata = badvaddr;
            CP0_STATUS:   cp0_rdata = status_word;
            CP0_CAUSE:    cp0_rdata = cause_word;
            CP0_EPC:      cp0_rdata = epc;
            default:      cp0_rdata = '0;
        endcase
    end

    assign pcselect.epc      = epc;
    assign hazard.eret_valid = eret_valid;

    // epc frozen once exl is up unless software moves it
    a_epc_held_in_exl: assert property (
        @(posedge clk) disable iff (reset)
        status.EXL && !(cp0_we && cp0_addr == CP0_EPC) |=> $stable(epc)
    ) else $error("epc changed with exl set");

endmodule

// File: hdl/exception.sv
`timescale 1ns/1ns

module exception
    import exception_pkg::*;
(
    input logic reset,
    exception_intf.excep self,
    pcselect_intf.exception pcselect,
    hazard_intf.exception hazard
);
    exception_info_t exc_info;
    logic            raw_valid;
    logic            exception_valid;
    exc_code_t       exccode;
    exception_t      exception;

    assign exc_info = self.exc_info;

    // fixed priority with the earliest pipeline cause first
    always_comb begin
        raw_valid = 1'b1;
        exccode   = '0;
        priority case (1'b1)
            exc_info.instr: exccode = CODE_ADEL;
            exc_info.ri:    exccode = CODE_RI;
            exc_info.of:    exccode = CODE_OV;
            exc_info.sys:   exccode = CODE_SYS;
            exc_info.bp:    exccode = CODE_BP;
            exc_info.load:  exccode = CODE_ADEL;
            exc_info.save:  exccode = CODE_ADES;
            default: begin
                raw_valid = 1'b0;
                exccode   = '0;
            end
        endcase
    end

    // nothing is taken while the core sits in reset
    assign exception_valid = raw_valid & ~reset;

    // record for cp0
    assign exception.valid         = exception_valid;
    assign exception.code          = exccode;
    assign exception.location      = EXC_ENTRY;
    assign exception.pcplus8       = self.pcplus8;
    assign exception.in_delay_slot = self.in_delay_slot;
    assign exception.badvaddr      = self.badvaddr;
    assign self.exception          = exception;

    // same strobe to fetch and hazard
    assign pcselect.exception_valid = exception_valid;
    assign pcselect.pcexception     = exception.location;
    assign hazard.exception_valid   = exception_valid;

    // all three consumers see one quiet strobe during reset
    a_no_exc_in_reset: assert property (
        @(posedge self.clk)
        reset |-> !self.exception.valid && !pcselect.exception_valid
                  && !hazard.exception_valid
    ) else $error("exception raised during reset");

endmodule

// File: hdl/exception_intf.sv
`timescale 1ns/1ns

// memory-stage flags in, exception record out
interface exception_intf
    import exception_pkg::*;
(
    input logic clk
);
    exception_info_t exc_info;
    word_t           pcplus8;
    logic            in_delay_slot;
    word_t           badvaddr;
    exception_t      exception;

    modport excep(
        input  clk, exc_info, pcplus8, in_delay_slot, badvaddr,
        output exception
    );
    modport cp0(
        input exception
    );
endinterface

// everything the pc selector needs to pick a redirect
interface pcselect_intf
    import exception_pkg::*;
();
    logic  exception_valid;
    word_t pcexception;
    word_t epc;
    word_t redirect;    // target held across a stall

    modport exception(
        output exception_valid, pcexception
    );
    modport cp0(
        output epc
    );
    modport hazard(
        input  pcexception, epc,
        output redirect
    );
    modport pcselect(
        input exception_valid, pcexception, epc, redirect
    );
endinterface

// flush and pending-redirect control
interface hazard_intf;
    logic exception_valid;
    logic eret_valid;
    logic flush;
    logic hold_redirect;

    modport exception(
        output exception_valid
    );
    modport cp0(
        output eret_valid
    );
    modport hazard(
        input  exception_valid, eret_valid,
        output flush, hold_redirect
    );
    modport pcselect(
        input flush, hold_redirect
    );
endinterface

// File: hdl/exception_pkg.sv
package exception_pkg;

    // one machine word
    typedef logic [31:0] word_t;

    // cause.exccode field
    typedef logic [4:0] exc_code_t;

    // mips exception codes in use
    // interrupts are outside this design so CODE_INT is never raised
    localparam exc_code_t CODE_INT  = 5'd0;
    localparam exc_code_t CODE_ADEL = 5'd4;
    localparam exc_code_t CODE_ADES = 5'd5;
    localparam exc_code_t CODE_SYS  = 5'd8;
    localparam exc_code_t CODE_BP   = 5'd9;
    localparam exc_code_t CODE_RI   = 5'd10;
    localparam exc_code_t CODE_OV   = 5'd12;

    // raw flags of the memory-stage instruction
    typedef struct packed {
        logic instr;    // fetch address error
        logic ri;       // reserved instruction
        logic of;       // arithmetic overflow
        logic sys;      // syscall
        logic bp;       // break
        logic load;     // load address error
        logic save;     // store address error
    } exception_info_t;

    // exception record handed to cp0
    typedef struct packed {
        logic      valid;
        exc_code_t code;
        word_t     location;
        word_t     pcplus8;
        logic      in_delay_slot;
        word_t     badvaddr;
    } exception_t;

    // status fields kept by this design
    // everything else in the register reads as zero
    typedef struct packed {
        logic       BEV;
        logic [7:0] IM;
        logic       ERL;
        logic       EXL;
        logic       IE;
    } cp0_status_t;

    // cp0 register number as seen by mfc0/mtc0
    typedef logic [4:0] cp0_addr_t;

    localparam cp0_addr_t CP0_BADVADDR = 5'd8;
    localparam cp0_addr_t CP0_STATUS   = 5'd12;
    localparam cp0_addr_t CP0_CAUSE    = 5'd13;
    localparam cp0_addr_t CP0_EPC      = 5'd14;

    // status bit positions inside the 32-bit word
    localparam int STATUS_BEV_BIT = 22;
    localparam int STATUS_IM_LSB  = 8;
    localparam int STATUS_ERL_BIT = 2;
    localparam int STATUS_EXL_BIT = 1;
    localparam int STATUS_IE_BIT  = 0;

    // cause bit positions
    localparam int CAUSE_BD_BIT  = 31;
    localparam int CAUSE_EXC_LSB = 2;

    // fixed vector without bev/offset selection
    localparam word_t EXC_ENTRY = 32'hBFC00380;

    // fetch address after reset
    localparam word_t RESET_PC = 32'hBFC00000;

endpackage

// File: hdl/exception_top.sv
`timescale 1ns/1ns

module exception_top
    import exception_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  exception_info_t exc_info,
    input  word_t           pcplus8,
    input  logic            in_delay_slot,
    input  word_t           badvaddr,
    input  logic            eret,
    input  logic            branch_taken,
    input  word_t           branch_target,
    input  logic            stall,
    input  logic            cp0_we,
    input  cp0_addr_t       cp0_addr,
    input  word_t           cp0_wdata,
    output word_t           pc,
    output word_t           cp0_rdata,
    output logic            flush,
    output logic            exception_valid,
    output exc_code_t       exc_code
);
    exception_intf excep_if (.clk(clk));
    pcselect_intf  pcsel_if ();
    hazard_intf    hazard_if ();

    // memory-stage inputs onto the exception bus
    assign excep_if.exc_info      = exc_info;
    assign excep_if.pcplus8       = pcplus8;
    assign excep_if.in_delay_slot = in_delay_slot;
    assign excep_if.badvaddr      = badvaddr;

    exception i_exception (
        .reset    (reset),
        .self     (excep_if),
        .pcselect (pcsel_if),
        .hazard   (hazard_if)
    );

    cp0_regs i_cp0 (
        .clk       (clk),
        .reset     (reset),
        .eret      (eret),
        .cp0_we    (cp0_we),
        .cp0_addr  (cp0_addr),
        .cp0_wdata (cp0_wdata),
        .cp0_rdata (cp0_rdata),
        .excep     (excep_if),
        .pcselect  (pcsel_if),
        .hazard    (hazard_if)
    );

    hazard i_hazard (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .self     (hazard_if),
        .pcselect (pcsel_if)
    );

    pc_select i_pc_select (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc            (pc),
        .self          (pcsel_if),
        .hazard        (hazard_if)
    );

    // status outputs straight from the record
    assign flush           = hazard_if.flush;
    assign exception_valid = excep_if.exception.valid;
    assign exc_code        = excep_if.exception.code;

endmodule

// File: hdl/hazard.sv
`timescale 1ns/1ns

module hazard
    import exception_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic stall,
    hazard_intf.hazard self,
    pcselect_intf.hazard pcselect
);
    logic  redirect_now;
    logic  hold_redirect;
    word_t redirect;

    // exception or eret both kill younger instructions
    assign redirect_now = self.exception_valid | self.eret_valid;
    assign self.flush   = redirect_now;

    // pending flag drops on the first unstalled edge
    always_ff @(posedge clk) begin
        if (reset) begin
            hold_redirect <= 1'b0;
        end else if (!stall) begin
            hold_redirect <= 1'b0;
        end else if (redirect_now) begin
            hold_redirect <= 1'b1;
        end
    end

    // target kind with epc as it stands at this edge
    always_ff @(posedge clk) begin
        if (stall && redirect_now) begin
            redirect <= self.exception_valid ? pcselect.pcexception : pcselect.epc;
        end
    end

    assign self.hold_redirect = hold_redirect;
    assign pcselect.redirect  = redirect;

    // held target is stable until absorbed or replaced
    a_held_kind_stable: assert property (
        @(posedge clk) disable iff (reset)
        hold_redirect && stall && !redirect_now |=> hold_redirect && $stable(redirect)
    ) else $error("held redirect lost during stall");

endmodule

// File: hdl/pc_select.sv
`timescale 1ns/1ns

module pc_select
    import exception_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  stall,
    input  logic  branch_taken,
    input  word_t branch_target,
    output word_t pc,
    pcselect_intf.pcselect self,
    hazard_intf.pcselect hazard
);
    word_t pc_next;

    // next fetch address, highest priority first
    always_comb begin
        if (hazard.hold_redirect) begin
            // redirect saved during a stall
            pc_next = self.redirect;
        end else if (self.exception_valid) begin
            pc_next = self.pcexception;
        end else if (hazard.flush) begin
            // flush without exception means eret
            pc_next = self.epc;
        end else if (branch_taken) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    // fetch pc frozen while stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00
    ) else $error("fetch pc not word aligned");

endmodule
